/* Makefile */
SIM := obj_dir/Vtb_board_top

.PHONY: all run clean

all: $(SIM)

$(SIM): build.f $(wildcard src/*.sv) $(wildcard verif/*.sv) $(wildcard verif/*.svh)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_board_top -f build.f

run: $(SIM)
	./$(SIM) | tee sim.log
	@if grep -q "=== FAIL ===" sim.log; then exit 1; fi
	@grep -q "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log

/* build.f */
+incdir+verif
src/audio_pkg.sv
src/board_pkg.sv
src/mic_i2s_receiver.sv
src/sample_scaler.sv
src/sample_fifo.sv
src/i2s_audio_out.sv
src/board_specific_top.sv
verif/tb_board_top.sv

/* src/audio_pkg.sv */
package audio_pkg;

    // ------------------------------
    // Word widths
    // ------------------------------

    localparam int mic_bits   = 24;                   // INMP441 style sample
    localparam int pcm_bits   = 16;                   // DAC word

    // Arithmetic shift that maps a mic word onto PCM at zero attenuation
    localparam int scale_base = mic_bits - pcm_bits;

    // ------------------------------
    // I2S framing
    // ------------------------------

    localparam int slot_bits  = 32;                   // Serial clocks per channel
                                                      // Two slots per frame, 64 in all

    // ------------------------------
    // Sample types
    // ------------------------------

    typedef logic signed [mic_bits - 1:0] mic_word_t; // Raw microphone sample
    typedef logic signed [pcm_bits - 1:0] pcm_t;      // Scaled DAC sample

endpackage

/* src/board_pkg.sv */
package board_pkg;

    // ------------------------------
    // Board control widths
    // ------------------------------

    localparam int w_key   = 2;                 // Push buttons, active low
    localparam int w_sw    = 4;                 // Top switch doubles as reset
    localparam int w_led   = 8;                 // Level meter LEDs

    localparam int w_shift = 3;                 // Attenuation step, 0..7

    // ------------------------------
    // Audio controls
    // ------------------------------

    typedef struct packed
    {
        logic                 mute;             // Force silence
        logic [w_shift - 1:0] shift;            // Extra right shift
    } audio_ctrl_t;

endpackage

/* src/board_specific_top.sv */
module board_specific_top
    import audio_pkg::*,
           board_pkg::*;
#(
    parameter int sck_div    = 8,                          // Shared by mic and DAC
    parameter int fifo_depth = 4
)
(
    input  logic               clk,
    input  logic               rst,                        // From the top switch

    input  logic [w_key - 1:0] key,                        // Active low
    input  logic [w_sw  - 1:0] sw,                         // sw[3] is board reset
    output logic [w_led - 1:0] led,

    input  logic               mic_sd,
    output logic               mic_sck,
    output logic               mic_ws,
    output logic               mic_lr,                     // Channel select strap

    output logic               overflow,

    output logic               dac_mclk,
    output logic               dac_bclk,
    output logic               dac_lrclk,
    output logic               dac_sdata
);

    audio_ctrl_t ctrl;

    logic        mic_valid;
    mic_word_t   mic_data;
    logic        pcm_valid;
    pcm_t        pcm_data;

    logic        pop;
    pcm_t        head;
    logic        empty;

    // ------------------------------
    // Controls
    // ------------------------------

    assign ctrl.mute  = ~key[0];                           // Pressed means muted
    assign ctrl.shift = sw[w_shift - 1:0];

    assign mic_lr     = 1'b0;                              // Mic answers in left slot

    // ------------------------------
    // Producer, buffer, consumer
    // ------------------------------

    mic_i2s_receiver #(.sck_div(sck_div)) i_mic
    (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .mic_sd    ( mic_sd    ),
        .mic_sck   ( mic_sck   ),
        .mic_ws    ( mic_ws    ),
        .mic_valid ( mic_valid ),
        .mic_data  ( mic_data  )
    );

    sample_scaler i_scaler
    (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .ctrl      ( ctrl      ),
        .mic_valid ( mic_valid ),
        .mic_data  ( mic_data  ),
        .pcm_valid ( pcm_valid ),
        .pcm_data  ( pcm_data  ),
        .led       ( led       )
    );

    sample_fifo #(.payload_t(pcm_t), .fifo_depth(fifo_depth)) i_fifo
    (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .push      ( pcm_valid ),
        .push_data ( pcm_data  ),
        .pop       ( pop       ),
        .head      ( head      ),
        .empty     ( empty     ),
        .overflow  ( overflow  )
    );

    i2s_audio_out #(.sck_div(sck_div)) i_audio_out
    (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .head      ( head      ),
        .empty     ( empty     ),
        .pop       ( pop       ),
        .dac_mclk  ( dac_mclk  ),
        .dac_bclk  ( dac_bclk  ),
        .dac_lrclk ( dac_lrclk ),
        .dac_sdata ( dac_sdata )
    );

endmodule

/* src/i2s_audio_out.sv */
module i2s_audio_out
    import audio_pkg::*;
#(
    parameter int sck_div = 8                              // Same divider as the receiver
)
(
    input  logic clk,
    input  logic rst,

    input  pcm_t head,                                     // FIFO head word
    input  logic empty,
    output logic pop,                                      // One per frame at most

    output logic dac_mclk,                                 // clk / 2
    output logic dac_bclk,
    output logic dac_lrclk,                                // Low selects left slot
    output logic dac_sdata
);

    localparam int w_div = $clog2(sck_div + 1);
    localparam int w_bit = $clog2(slot_bits);

    logic [w_div - 1:0] div_cnt;
    logic [w_bit - 1:0] bit_cnt;                           // bclk periods into the slot

    logic               bclk_tick;
    logic               bclk_fall;
    logic               lr_fall;                           // lrclk goes low on this edge
    logic               next_bit;
    pcm_t               word;                              // Word sent in both slots

    assign bclk_tick = div_cnt == w_div'(sck_div - 1);
    assign bclk_fall = bclk_tick & dac_bclk;
    assign lr_fall   = bclk_fall & dac_lrclk & (bit_cnt == w_bit'(slot_bits - 1));

    // Bit k of the slot carries word bit 15-k, tail of the slot is zero
    assign next_bit  = (bit_cnt < pcm_bits) ? word[pcm_bits - 1 - bit_cnt] : 1'b0;

    // ------------------------------
    // DAC clocks
    // ------------------------------

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            dac_mclk  <= 1'b0;
            div_cnt   <= '0;
            dac_bclk  <= 1'b0;
            bit_cnt   <= '0;
            dac_lrclk <= 1'b0;
        end
        else
        begin
            dac_mclk <= ~dac_mclk;
            div_cnt  <= bclk_tick ? '0 : div_cnt + 1'b1;

            if (bclk_tick)
                dac_bclk <= ~dac_bclk;

            if (bclk_fall)
            begin
                bit_cnt <= bit_cnt + 1'b1;                 // Wraps at slot end

                if (bit_cnt == w_bit'(slot_bits - 1))
                    dac_lrclk <= ~dac_lrclk;
            end
        end
    end

    // ------------------------------
    // Fetch and serializer
    // ------------------------------

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            pop       <= 1'b0;
            word      <= '0;                               // Silence until first pop
            dac_sdata <= 1'b0;
        end
        else
        begin
            pop <= lr_fall & ~empty;                       // High in the lrclk fall cycle

            // Empty FIFO leaves the old word in place for a repeat
            if (pop)
                word <= head;

            // MSB goes out one bclk after the lrclk edge
            if (bclk_fall)
                dac_sdata <= next_bit;
        end
    end

    // FIFO reads stay locked to the frame boundary
    pop_on_frame : assert property (@(posedge clk) disable iff (rst)
        pop |-> $fell(dac_lrclk))
        else $error("pop outside lrclk fall");

endmodule

/* src/mic_i2s_receiver.sv */
module mic_i2s_receiver
    import audio_pkg::*;
#(
    parameter int sck_div = 8                              // clk cycles per half sck
)
(
    input  logic      clk,
    input  logic      rst,

    input  logic      mic_sd,                              // Serial data from mic
    output logic      mic_sck,
    output logic      mic_ws,                              // Low selects left slot

    output logic      mic_valid,
    output mic_word_t mic_data
);

    localparam int w_div = $clog2(sck_div + 1);
    localparam int w_bit = $clog2(slot_bits);

    logic [w_div - 1:0] div_cnt;
    logic [w_bit - 1:0] bit_cnt;                           // sck periods into the slot

    logic               sck_tick;
    logic               sck_rise;
    logic               sck_fall;
    logic               ws_q;                              // Delayed ws for edge detect
    mic_word_t          shreg;

    assign sck_tick = div_cnt == w_div'(sck_div - 1);
    assign sck_rise = sck_tick & ~mic_sck;                 // sck about to go high
    assign sck_fall = sck_tick &  mic_sck;                 // sck about to go low

    // ------------------------------
    // Serial clock and word select
    // ------------------------------

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            div_cnt <= '0;
            mic_sck <= 1'b0;
            bit_cnt <= '0;
            mic_ws  <= 1'b0;                               // Frame opens on left slot
        end
        else
        begin
            div_cnt <= sck_tick ? '0 : div_cnt + 1'b1;

            if (sck_tick)
                mic_sck <= ~mic_sck;

            // ws changes on the falling sck edge, count wraps at slot end
            if (sck_fall)
            begin
                bit_cnt <= bit_cnt + 1'b1;

                if (bit_cnt == w_bit'(slot_bits - 1))
                    mic_ws <= ~mic_ws;
            end
        end
    end

    // ------------------------------
    // Left slot deserializer
    // ------------------------------

    // MSB lands one sck after the ws edge, so bits 1..24 carry the word
    always_ff @(posedge clk)
    begin
        if (sck_rise && !mic_ws && bit_cnt != '0 && bit_cnt <= mic_bits)
            shreg <= {shreg[mic_bits - 2:0], mic_sd};      // MSB first
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            ws_q      <= 1'b0;
            mic_valid <= 1'b0;
        end
        else
        begin
            ws_q      <= mic_ws;
            mic_valid <= mic_ws & ~ws_q;                   // Cycle after ws rises
        end
    end

    always_ff @(posedge clk)
    begin
        if (mic_ws && !ws_q)
            mic_data <= shreg;                             // Left word is complete
    end

    // One word per frame, so the strobe can never stretch
    mic_valid_single : assert property (@(posedge clk) disable iff (rst)
        mic_valid |=> !mic_valid)
        else $error("mic_valid held for two cycles");

endmodule

/* src/sample_fifo.sv */
module sample_fifo
#(
    parameter type payload_t  = logic [15:0],
    parameter int  fifo_depth = 4                       // Power of two
)
(
    input  logic     clk,
    input  logic     rst,

    input  logic     push,                              // Strobe, dropped when full
    input  payload_t push_data,
    input  logic     pop,                               // Strobe, only while not empty

    output payload_t head,                              // Oldest entry
    output logic     empty,
    output logic     overflow                           // Sticky lost push
);

    localparam int w_ptr = $clog2(fifo_depth);
    localparam int w_cnt = $clog2(fifo_depth + 1);

    payload_t           mem [fifo_depth];
    logic [w_ptr - 1:0] wr_ptr;
    logic [w_ptr - 1:0] rd_ptr;
    logic [w_cnt - 1:0] count;

    logic               full;
    logic               do_push;
    logic               do_pop;

    assign empty   = count == '0;
    assign full    = count == w_cnt'(fifo_depth);
    assign do_push = push & ~full;
    assign do_pop  = pop  & ~empty;
    assign head    = mem[rd_ptr];

    // ------------------------------
    // Storage
    // ------------------------------

    always_ff @(posedge clk)
    begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

    // ------------------------------
    // Pointers and fill level
    // ------------------------------

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;                // Wraps at depth

            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;

            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;                // Both or neither
            endcase

            if (push && full)
                overflow <= 1'b1;                       // Stays until reset
        end
    end

    // The consumer must look at empty before it pops
    pop_not_empty : assert property (@(posedge clk) disable iff (rst)
        pop |-> !empty)
        else $error("pop while FIFO empty");

endmodule

/* src/sample_scaler.sv */
module sample_scaler
    import audio_pkg::*,
           board_pkg::*;
(
    input  logic               clk,
    input  logic               rst,

    input  audio_ctrl_t        ctrl,                      // Mute and attenuation
    input  logic               mic_valid,
    input  mic_word_t          mic_data,

    output logic               pcm_valid,
    output pcm_t               pcm_data,
    output logic [w_led - 1:0] led                        // Thermometer level meter
);

    localparam int led_base = 7;                          // LED 0 lights at 2**7

    mic_word_t            shifted;
    pcm_t                 pcm_next;
    logic [pcm_bits - 1:0] magnitude;                     // Unsigned level of pcm_data
    logic [w_led - 1:0]   led_next;

    // ------------------------------
    // Mic word to PCM
    // ------------------------------

    always_comb
    begin
        shifted  = mic_data >>> (scale_base + ctrl.shift); // Sign kept
        pcm_next = ctrl.mute ? '0 : pcm_t'(shifted[pcm_bits - 1:0]);
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            pcm_valid <= 1'b0;
        else
            pcm_valid <= mic_valid;                       // One cycle behind mic strobe
    end

    always_ff @(posedge clk)
    begin
        if (mic_valid)
            pcm_data <= pcm_next;
    end

    // ------------------------------
    // Level meter
    // ------------------------------

    always_comb
    begin
        magnitude = pcm_data[pcm_bits - 1] ? -pcm_data : pcm_data;

        // Negating -32768 wraps to 0x8000, pull it back to full scale
        if (magnitude[pcm_bits - 1])
            magnitude = {1'b0, {(pcm_bits - 1){1'b1}}};

        for (int i = 0; i < w_led; i++)
            led_next[i] = magnitude >= (1 << (led_base + i));
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            led <= '0;
        else if (pcm_valid)
            led <= led_next;                              // Holds until next word
    end

endmodule

/* verif/tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// ------------------------------
// Reference model
// ------------------------------

// Drop 8 plus shift bits, sign kept, low 16 bits survive
function automatic pcm_t scale_ref(input mic_word_t word, input audio_ctrl_t ctrl);
    int full;
    if (ctrl.mute)
        return '0;                                          // Muted means silence
    full = word;                                            // Sign extends to 32 bits
    full = full >>> (8 + ctrl.shift);
    return pcm_t'(full);
endfunction

// Thermometer meter, LED i at 128 << i
function automatic logic [w_led - 1:0] level_ref(input pcm_t pcm);
    int                 level;
    logic [w_led - 1:0] lights;
    level = pcm;
    if (level < 0)
        level = -level;
    if (level > 32767)
        level = 32767;                                      // -32768 reads as full scale
    for (int i = 0; i < w_led; i++)
        lights[i] = level >= (128 << i);
    return lights;
endfunction

// ------------------------------
// Compare tasks
// ------------------------------

task automatic check_pcm(input string name, input pcm_t got, input pcm_t exp);
    if (got !== exp)
    begin
        $display("FAILED %0t %s got %h (%0d) expected %h (%0d)",
                 $time, name, got, got, exp, exp);
        err_pcm++;
    end
endtask

task automatic check_led(input string name, input logic [w_led - 1:0] got,
                         input logic [w_led - 1:0] exp);
    if (got !== exp)
    begin
        $display("FAILED %0t %s got %b expected %b", $time, name, got, exp);
        err_led++;
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
        $display("FAILED %0t %s got %b expected %b", $time, name, got, exp);
        err_flag++;
    end
endtask

`endif

/* verif/tb_board_top.sv */
module tb_board_top
    import audio_pkg::*,
           board_pkg::*;
();

    localparam int sck_div        = 2;
    localparam int frame_cycles   = 128 * sck_div;
    localparam int test_frames    = 10 + 7 * 4 + 4 + 6 + 8 + 2;
    localparam int timeout_cycles = test_frames * frame_cycles * 12 / 10;

    typedef struct packed
    {
        mic_word_t   word;                                  // Sent by the mic model
        audio_ctrl_t ctrl;                                  // Controls at the ws rise
        logic [31:0] cycle;
    } exp_entry_t;

    logic               clk;
    logic               rst;
    logic [w_key - 1:0] key;
    logic [w_sw  - 1:0] sw;
    logic               mic_sd;
    logic [w_led - 1:0] led;
    logic               mic_sck;
    logic               mic_ws;
    logic               mic_lr;
    logic               overflow;
    logic               dac_mclk;
    logic               dac_bclk;
    logic               dac_lrclk;
    logic               dac_sdata;

    int                 err_pcm       = 0;
    int                 err_led       = 0;
    int                 err_flag      = 0;
    int                 err_other     = 0;
    int                 cycle         = 0;
    int                 frame_cnt     = 0;                  // Decoded DAC frames
    int                 checked       = 0;
    int                 skipped       = 0;
    int                 muted_checked = 0;
    integer             seed          = 32'h233d;
    exp_entry_t         exp_q[$];
    int                 change_q[$];                        // Cycles of control changes

    `include "tb_checks.svh"

    board_specific_top #(.sck_div(sck_div)) u_dut
    (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .key       ( key       ),
        .sw        ( sw        ),
        .led       ( led       ),
        .mic_sd    ( mic_sd    ),
        .mic_sck   ( mic_sck   ),
        .mic_ws    ( mic_ws    ),
        .mic_lr    ( mic_lr    ),
        .overflow  ( overflow  ),
        .dac_mclk  ( dac_mclk  ),
        .dac_bclk  ( dac_bclk  ),
        .dac_lrclk ( dac_lrclk ),
        .dac_sdata ( dac_sdata )
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk)
        cycle <= cycle + 1;

    // Keys pull low when pressed
    function automatic audio_ctrl_t board_ctrl(input logic [w_key - 1:0] k,
                                               input logic [w_sw - 1:0] s);
        audio_ctrl_t c;
        c.mute  = !k[0];
        c.shift = s[2:0];
        return c;
    endfunction

    function automatic bit near_change(input int at);
        foreach (change_q[i])
        begin
            if (change_q[i] - at < frame_cycles && at - change_q[i] < frame_cycles)
                return 1'b1;
        end
        return 1'b0;
    endfunction

    // ------------------------------
    // Microphone model
    // ------------------------------

    logic       sck_q   = 1'b0;
    logic       ws_seen = 1'b0;                             // Reset opens a left slot
    int         mic_pos = 0;                                // sck falls since ws edge
    int         word_idx = 0;
    mic_word_t  tx_word = '0;
    exp_entry_t entry;

    always @(posedge clk)
    begin
        sck_q <= mic_sck;
        if (sck_q && !mic_sck)                              // sck fell one cycle ago
        begin
            if (mic_ws != ws_seen)
            begin
                if (mic_ws)                                 // Left slot just closed
                begin
                    entry.word  = tx_word;
                    entry.ctrl  = board_ctrl(key, sw);
                    entry.cycle = cycle;
                    exp_q.push_back(entry);
                end
                mic_pos = 0;
            end
            else
                mic_pos = mic_pos + 1;
            ws_seen = mic_ws;

            if (!mic_ws && mic_pos == 1)
            begin
                word_idx = word_idx + 1;
                tx_word  = mic_word_t'($random(seed));
                if (word_idx % 8 == 3)
                    tx_word = {1'b1, {(mic_bits - 1){1'b0}}};   // Most negative
                else if (word_idx % 8 == 6)
                    tx_word[mic_bits - 1 -: 2] = 2'b10;     // Large negative
                else if (tx_word[mic_bits - 1:8] == '0)
                    tx_word[8] = 1'b1;                      // Nonzero at zero shift
            end

            // MSB one sck after the ws edge, zeros past bit 24
            if (!mic_ws && mic_pos >= 1 && mic_pos <= mic_bits)
                mic_sd <= tx_word[mic_bits - mic_pos];
            else
                mic_sd <= 1'b0;
        end
    end

    // ------------------------------
    // DAC decoder and scoreboard
    // ------------------------------

    logic bclk_q    = 1'b0;
    logic lr_seen   = 1'b0;
    logic started   = 1'b0;                                 // First nonzero frame seen
    int   dac_pos   = -1;                                   // First rise is the pad bit
    pcm_t shift_acc = '0;
    pcm_t left_acc  = '0;

    task automatic score_frame(input pcm_t left, input pcm_t right);
        exp_entry_t e;
        pcm_t       exp_pcm;
        frame_cnt++;
        check_flag("overflow", overflow, 1'b0);
        check_flag("mic_lr", mic_lr, 1'b0);
        if (!started && left == '0 && right == '0)
            return;                                         // Silence before first pop
        started = 1'b1;
        if (exp_q.size() == 0)
        begin
            $display("%0t: DAC frame arrived with no microphone word pending", $time);
            err_other++;
            return;
        end
        e = exp_q.pop_front();
        if (near_change(e.cycle))
            skipped++;                                      // Controls moving at capture
        else
        begin
            exp_pcm = scale_ref(e.word, e.ctrl);
            check_pcm("dac left", left, exp_pcm);
            check_pcm("dac right", right, exp_pcm);
            checked++;
            if (e.ctrl.mute)
                muted_checked++;
        end
        // Meter already shows the newest word, captured half a frame ago
        if (exp_q.size() > 0 && !near_change(exp_q[$].cycle))
            check_led("led", led, level_ref(scale_ref(exp_q[$].word, exp_q[$].ctrl)));
    endtask

    always @(posedge clk)
    begin
        bclk_q <= dac_bclk;
        if (!bclk_q && dac_bclk)                            // bclk rose, data is stable
        begin
            if (dac_lrclk != lr_seen)
            begin
                if (lr_seen)
                    score_frame(left_acc, shift_acc);       // Right slot closes the frame
                else
                    left_acc = shift_acc;
                lr_seen = dac_lrclk;
                dac_pos = 0;
            end
            else
                dac_pos = dac_pos + 1;

            if (dac_pos >= 1 && dac_pos <= pcm_bits)
                shift_acc = {shift_acc[pcm_bits - 2:0], dac_sdata};
            else
                check_flag("dac_sdata", dac_sdata, 1'b0);   // Pad bits
        end
    end

    // MCLK flips on every clk edge once reset is gone
    logic mclk_q = 1'b0;
    logic rst_q  = 1'b1;

    always @(posedge clk)
    begin
        if (!rst_q)
            check_flag("dac_mclk", dac_mclk, !mclk_q);
        mclk_q <= dac_mclk;
        rst_q  <= rst;
    end

    // ------------------------------
    // Stimulus
    // ------------------------------

    task automatic set_controls(input logic [w_key - 1:0] k, input logic [w_sw - 1:0] s);
        @(posedge clk);
        key <= k;
        sw  <= s;
        change_q.push_back(cycle);
    endtask

    task automatic wait_frames(input int n);
        int target;
        target = frame_cnt + n;
        while (frame_cnt < target)
            @(posedge clk);
    endtask

    initial
    begin
        rst    = 1'b1;
        key    = '1;                                        // Keys released
        sw     = '0;
        mic_sd = 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        wait_frames(10);                                    // Zero attenuation
        for (int s = 1; s < 8; s++)
        begin
            set_controls(2'b11, w_sw'(s));
            wait_frames(4);
        end
        set_controls(2'b11, 4'd0);
        wait_frames(4);

        set_controls(2'b10, 4'd0);                          // Hold key 0
        wait_frames(6);
        set_controls(2'b11, 4'd0);
        wait_frames(8);

        if (checked < 30)
        begin
            $display("Only %0d DAC frames were compared, too few", checked);
            err_other++;
        end
        if (muted_checked == 0)
        begin
            $display("No muted word reached the comparison");
            err_other++;
        end
        $display("Errors: pcm %0d led %0d flag %0d other %0d, checked %0d skipped %0d",
                 err_pcm, err_led, err_flag, err_other, checked, skipped);
        if (err_pcm + err_led + err_flag + err_other == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

    initial
    begin
        wait (cycle >= timeout_cycles);
        $display("Timeout: the test did not end within %0d clock cycles", cycle);
        $display("=== FAIL ===");
        $finish;
    end

endmodule
